//--- Makefile
LOG = sim.log

all: run

compile:
	verilator --binary --timing -j 0 -f list.f --top-module tb_data_cache -o sim_data_cache

run: compile
	./obj_dir/sim_data_cache > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all compile run clean

//--- cache_addr_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_addr_pkg;

    // one data word as seen by the cpu
    typedef logic [31:0] word_t;

    // byte lane select, 0 is the most significant byte
    typedef logic [`CACHE_WORD_ADDR_LEN-1:0] byte_off_t;

    // word index inside a line
    typedef logic [`CACHE_LINE_ADDR_LEN-1:0] word_sel_t;

    typedef logic [`CACHE_SET_ADDR_LEN-1:0] set_idx_t;

    typedef logic [`CACHE_TAG_ADDR_LEN-1:0] tag_t;

    typedef logic [$clog2(`CACHE_WAY_CNT)-1:0] way_idx_t;

    // line number in memory, tag on top of set
    typedef logic [`CACHE_TAG_ADDR_LEN+`CACHE_SET_ADDR_LEN-1:0] line_addr_t;

    // low 18 address bits split into their fields, msb first
    typedef struct packed {
        tag_t      tag;
        set_idx_t  set;
        word_sel_t word_sel;
        byte_off_t byte_off;
    } addr_fields_t;

endpackage

`default_nettype wire

//--- cache_data_array.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module cache_data_array
    import cache_addr_pkg::*, cache_xact_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire cpu_req_t     cpu_req_i,
    input  wire addr_fields_t fields_i,
    input  wire line_sel_t    ctrl_line_i,
    input  wire               load_i,
    input  wire               store_i,
    input  wire               fill_i,
    input  wire cache_line_t  mem_read_line_i,
    output word_t             read_data_o,
    output cache_line_t       victim_line_o
);

    // 8 sets x 4 ways of whole lines
    cache_line_t line_mem [`CACHE_SET_CNT][`CACHE_WAY_CNT];

    word_t cur_word;
    word_t merged_word;

    // addressed word of the selected slot
    assign cur_word = line_mem[ctrl_line_i.set][ctrl_line_i.way][fields_i.word_sel];

    // whole slot for write-back
    assign victim_line_o = line_mem[ctrl_line_i.set][ctrl_line_i.way];

    // store merge, big-endian lanes: offset 0 is bits 31:24
    always_comb
    begin
        merged_word = cur_word;
        case (cpu_req_i.store_type)
            STORE_BYTE:
            begin
                case (fields_i.byte_off)
                    2'd0: merged_word[31:24] = cpu_req_i.wdata[7:0];
                    2'd1: merged_word[23:16] = cpu_req_i.wdata[7:0];
                    2'd2: merged_word[15:8]  = cpu_req_i.wdata[7:0];
                    default: merged_word[7:0] = cpu_req_i.wdata[7:0];
                endcase
            end
            STORE_HALF:
            begin
                // odd offsets leave the word untouched
                case (fields_i.byte_off)
                    2'd0: merged_word[31:16] = cpu_req_i.wdata[15:0];
                    2'd2: merged_word[15:0]  = cpu_req_i.wdata[15:0];
                    default: merged_word = cur_word;
                endcase
            end
            // word store and any unknown code
            default:
            begin
                merged_word = cpu_req_i.wdata;
            end
        endcase
    end

    // line storage, fill replaces the full line
    always_ff @(posedge clk)
    begin
        if (fill_i)
        begin
            line_mem[ctrl_line_i.set][ctrl_line_i.way] <= mem_read_line_i;
        end
        else if (store_i)
        begin
            line_mem[ctrl_line_i.set][ctrl_line_i.way][fields_i.word_sel] <= merged_word;
        end
    end

    // read data held until the next load
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            read_data_o <= '0;
        end
        else if (load_i)
        begin
            read_data_o <= cur_word;
        end
    end

endmodule

`default_nettype wire

//--- cache_miss_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module cache_miss_ctrl
    import cache_addr_pkg::*, cache_xact_pkg::*;
(
    input  wire                clk,
    input  wire                rst,
    input  wire cpu_req_t      cpu_req_i,
    input  wire addr_fields_t  fields_i,
    input  wire                hit_i,
    input  wire way_idx_t      hit_way_i,
    input  wire                victim_valid_i,
    input  wire                victim_dirty_i,
    input  wire tag_t          victim_tag_i,
    input  wire cache_line_t   victim_line_i,
    input  wire                mem_request_finish_i,
    output line_sel_t          ctrl_line_o,
    output logic               fill_o,
    output logic               store_o,
    output logic               load_o,
    output tag_t               fill_tag_o,
    output mem_req_t           mem_req_o,
    output logic               request_finish_o,
    output logic               miss_o
);

    ctrl_state_e state_q;

    // fifo victim pointer, one per set
    way_idx_t rr_ptr_q [`CACHE_SET_CNT];

    // miss context
    set_idx_t    miss_set_q;
    tag_t        miss_tag_q;
    way_idx_t    miss_way_q;

    // memory request fields
    logic        mem_rd_q;
    logic        mem_wr_q;
    word_t       mem_addr_q;
    cache_line_t mem_line_q;

    logic req_valid;
    logic ready_hit;
    logic ready_miss;
    logic victim_wb;

    // line number to byte address, offset bits zero
    function automatic word_t line_to_addr(line_addr_t line);
        return word_t'(line) << `CACHE_OFFSET_LEN;
    endfunction

    assign req_valid  = cpu_req_i.read || cpu_req_i.write;
    assign ready_hit  = (state_q == READY) && req_valid && hit_i;
    assign ready_miss = (state_q == READY) && req_valid && !hit_i;
    // only a valid and dirty victim needs a write-back
    assign victim_wb  = victim_valid_i && victim_dirty_i;

    assign miss_o  = ready_miss;
    // read wins over write if both are raised
    assign load_o  = ready_hit && cpu_req_i.read;
    assign store_o = ready_hit && !cpu_req_i.read && cpu_req_i.write;
    assign fill_o  = (state_q == REPLACE_IN) && mem_request_finish_i;
    assign fill_tag_o = miss_tag_q;

    assign mem_req_o = '{read: mem_rd_q, write: mem_wr_q, addr: mem_addr_q, wline: mem_line_q};

    // in READY point at the hit way, else at the victim
    always_comb
    begin
        if (state_q == READY)
        begin
            ctrl_line_o.set = fields_i.set;
            ctrl_line_o.way = hit_i ? hit_way_i : rr_ptr_q[fields_i.set];
        end
        else
        begin
            ctrl_line_o.set = miss_set_q;
            ctrl_line_o.way = miss_way_q;
        end
    end

    // state, handshake levels and pointers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q          <= READY;
            request_finish_o <= 1'b0;
            mem_rd_q         <= 1'b0;
            mem_wr_q         <= 1'b0;
            for (int s = 0; s < `CACHE_SET_CNT; s++)
            begin
                rr_ptr_q[s] <= '0;
            end
        end
        else
        begin
            // finish is a single-cycle pulse
            request_finish_o <= 1'b0;
            case (state_q)
                READY:
                begin
                    if (ready_hit)
                    begin
                        request_finish_o <= 1'b1;
                        state_q          <= RESPOND;
                    end
                    else if (ready_miss && victim_wb)
                    begin
                        mem_wr_q <= 1'b1;
                        state_q  <= REPLACE_OUT;
                    end
                    else if (ready_miss)
                    begin
                        mem_rd_q <= 1'b1;
                        state_q  <= REPLACE_IN;
                    end
                end
                // cpu drops its request during this cycle
                RESPOND:
                begin
                    state_q <= READY;
                end
                REPLACE_OUT:
                begin
                    if (mem_request_finish_i)
                    begin
                        mem_wr_q <= 1'b0;
                        mem_rd_q <= 1'b1;
                        state_q  <= REPLACE_IN;
                    end
                end
                REPLACE_IN:
                begin
                    if (mem_request_finish_i)
                    begin
                        mem_rd_q <= 1'b0;
                        state_q  <= READY;
                        // wrap from the last way back to way 0
                        if (rr_ptr_q[miss_set_q] == way_idx_t'(`CACHE_WAY_CNT - 1))
                        begin
                            rr_ptr_q[miss_set_q] <= '0;
                        end
                        else
                        begin
                            rr_ptr_q[miss_set_q] <= rr_ptr_q[miss_set_q] + 1'b1;
                        end
                    end
                end
                default:
                begin
                    state_q <= READY;
                end
            endcase
        end
    end

    // miss context and memory address/line
    always_ff @(posedge clk)
    begin
        if (ready_miss)
        begin
            miss_set_q <= fields_i.set;
            miss_tag_q <= fields_i.tag;
            miss_way_q <= rr_ptr_q[fields_i.set];
            mem_line_q <= victim_line_i;
            // write-back goes to the victim's own line
            if (victim_wb)
            begin
                mem_addr_q <= line_to_addr({victim_tag_i, fields_i.set});
            end
            else
            begin
                mem_addr_q <= line_to_addr({fields_i.tag, fields_i.set});
            end
        end
        else if ((state_q == REPLACE_OUT) && mem_request_finish_i)
        begin
            // refill address of the pending request
            mem_addr_q <= line_to_addr({miss_tag_q, miss_set_q});
        end
    end

endmodule

`default_nettype wire

//--- cache_params.svh
`ifndef CACHE_PARAMS_SVH
`define CACHE_PARAMS_SVH

// byte offset inside one 32-bit word
`define CACHE_WORD_ADDR_LEN 2

// word select inside a line, 8 words per line
`define CACHE_LINE_ADDR_LEN 3

// set index, 8 sets
`define CACHE_SET_ADDR_LEN 3

// tag bits above the set index
`define CACHE_TAG_ADDR_LEN 10

// associativity
`define CACHE_WAY_CNT 4

// derived counts
`define CACHE_LINE_WORDS (1 << `CACHE_LINE_ADDR_LEN)
`define CACHE_SET_CNT (1 << `CACHE_SET_ADDR_LEN)

// low address bits dropped for a line-aligned address
`define CACHE_OFFSET_LEN (`CACHE_LINE_ADDR_LEN + `CACHE_WORD_ADDR_LEN)

`endif

//--- cache_tag_lookup.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module cache_tag_lookup
    import cache_addr_pkg::*, cache_xact_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire cpu_req_t     cpu_req_i,
    input  wire line_sel_t    ctrl_line_i,
    input  wire               fill_i,
    input  wire               store_i,
    input  wire tag_t         fill_tag_i,
    output addr_fields_t      fields_o,
    output logic              hit_o,
    output way_idx_t          hit_way_o,
    output logic              victim_valid_o,
    output logic              victim_dirty_o,
    output tag_t              victim_tag_o
);

    // tag store, only meaningful where valid is set
    tag_t tag_mem [`CACHE_SET_CNT][`CACHE_WAY_CNT];

    // per set, one bit per way
    logic [`CACHE_WAY_CNT-1:0] valid_q [`CACHE_SET_CNT];
    logic [`CACHE_WAY_CNT-1:0] dirty_q [`CACHE_SET_CNT];

    logic [`CACHE_WAY_CNT-1:0] hit_vec;

    // upper address bits above the tag are not decoded
    assign fields_o = addr_fields_t'(cpu_req_i.addr[$bits(addr_fields_t)-1:0]);

    // compare every way of the addressed set in parallel
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `CACHE_WAY_CNT; w++)
        begin
            hit_vec[w] = valid_q[fields_o.set][w] && (tag_mem[fields_o.set][w] == fields_o.tag);
            // at most one way can match
            if (hit_vec[w])
            begin
                hit_way_o = way_idx_t'(w);
            end
        end
    end

    assign hit_o = |hit_vec;

    // state of whatever slot the controller points at
    assign victim_valid_o = valid_q[ctrl_line_i.set][ctrl_line_i.way];
    assign victim_dirty_o = dirty_q[ctrl_line_i.set][ctrl_line_i.way];
    assign victim_tag_o   = tag_mem[ctrl_line_i.set][ctrl_line_i.way];

    // valid and dirty bits
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < `CACHE_SET_CNT; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (fill_i)
        begin
            // fresh line from memory, clean
            valid_q[ctrl_line_i.set][ctrl_line_i.way] <= 1'b1;
            dirty_q[ctrl_line_i.set][ctrl_line_i.way] <= 1'b0;
        end
        else if (store_i)
        begin
            dirty_q[ctrl_line_i.set][ctrl_line_i.way] <= 1'b1;
        end
    end

    // tag written on refill only
    always_ff @(posedge clk)
    begin
        if (fill_i)
        begin
            tag_mem[ctrl_line_i.set][ctrl_line_i.way] <= fill_tag_i;
        end
    end

endmodule

`default_nettype wire

//--- cache_xact_pkg.sv
`default_nettype none

`include "cache_params.svh"

package cache_xact_pkg;
    import cache_addr_pkg::*;

    // full line, word 0 in the top slot like the memory port
    typedef word_t [0:`CACHE_LINE_WORDS-1] cache_line_t;

    // unlisted codes are treated as a word store
    typedef enum logic [2:0] {
        STORE_BYTE = 3'd0,
        STORE_HALF = 3'd1,
        STORE_WORD = 3'd2
    } store_type_e;

    // cpu request, held until request_finish
    typedef struct packed {
        logic        read;
        logic        write;
        store_type_e store_type;
        word_t       addr;
        word_t       wdata;
    } cpu_req_t;

    // memory request, one of read or write at a time
    typedef struct packed {
        logic        read;
        logic        write;
        word_t       addr;
        cache_line_t wline;
    } mem_req_t;

    // names one line slot in the arrays
    typedef struct packed {
        set_idx_t set;
        way_idx_t way;
    } line_sel_t;

    typedef enum logic [1:0] {READY, RESPOND, REPLACE_OUT, REPLACE_IN} ctrl_state_e;

endpackage

`default_nettype wire

//--- data_cache.sv
`default_nettype none
`timescale 1ns/100ps

module data_cache
    import cache_addr_pkg::*, cache_xact_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    // cpu side
    input  wire cpu_req_t    cpu_req_i,
    output logic             request_finish_o,
    output word_t            read_data_o,
    output logic             miss_o,
    // memory side
    output mem_req_t         mem_req_o,
    input  wire              mem_request_finish_i,
    input  wire cache_line_t mem_read_line_i
);

    // lookup to controller
    addr_fields_t fields;
    logic         hit;
    way_idx_t     hit_way;
    logic         victim_valid;
    logic         victim_dirty;
    tag_t         victim_tag;

    // controller to arrays
    line_sel_t    ctrl_line;
    logic         fill;
    logic         store;
    logic         load;
    tag_t         fill_tag;

    // array to controller
    cache_line_t  victim_line;

    // decode: address split, tags and hit detect
    cache_tag_lookup u_tag_lookup (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_i      (cpu_req_i),
        .ctrl_line_i    (ctrl_line),
        .fill_i         (fill),
        .store_i        (store),
        .fill_tag_i     (fill_tag),
        .fields_o       (fields),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_valid_o (victim_valid),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // execute: miss FSM and memory requests
    cache_miss_ctrl u_miss_ctrl (
        .clk                  (clk),
        .rst                  (rst),
        .cpu_req_i            (cpu_req_i),
        .fields_i             (fields),
        .hit_i                (hit),
        .hit_way_i            (hit_way),
        .victim_valid_i       (victim_valid),
        .victim_dirty_i       (victim_dirty),
        .victim_tag_i         (victim_tag),
        .victim_line_i        (victim_line),
        .mem_request_finish_i (mem_request_finish_i),
        .ctrl_line_o          (ctrl_line),
        .fill_o               (fill),
        .store_o              (store),
        .load_o               (load),
        .fill_tag_o           (fill_tag),
        .mem_req_o            (mem_req_o),
        .request_finish_o     (request_finish_o),
        .miss_o               (miss_o)
    );

    // result: line data and read register
    cache_data_array u_data_array (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_i       (cpu_req_i),
        .fields_i        (fields),
        .ctrl_line_i     (ctrl_line),
        .load_i          (load),
        .store_i         (store),
        .fill_i          (fill),
        .mem_read_line_i (mem_read_line_i),
        .read_data_o     (read_data_o),
        .victim_line_o   (victim_line)
    );

endmodule

`default_nettype wire

//--- list.f
+incdir+.
cache_addr_pkg.sv
cache_xact_pkg.sv
cache_tag_lookup.sv
cache_miss_ctrl.sv
cache_data_array.sv
data_cache.sv
tb_main_memory.sv
tb_data_cache.sv

//--- tb_data_cache.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module tb_data_cache
    import cache_addr_pkg::*, cache_xact_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int RAND_OPS     = 80;
    localparam int EVICT_OPS    = 6;
    localparam int TRAFFIC_OPS  = 200;
    localparam int TOTAL_REQS   = 3 + RAND_OPS + EVICT_OPS + TRAFFIC_OPS;
    // cycle bound per request
    // a miss with write-back takes about 16
    localparam int REQ_TIMEOUT  = 40;

    typedef logic [$bits(line_addr_t)+$bits(word_sel_t)-1:0] word_addr_t;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    cpu_req_t    cpu_req;
    logic        request_finish;
    word_t       read_data;
    logic        miss;
    mem_req_t    mem_req;
    logic        mem_finish;
    cache_line_t mem_line;
    logic        wb_valid;
    line_addr_t  wb_line;

    // shadow memory image by word address
    word_t      shadow [word_addr_t];
    // tag state model for miss and write-back prediction
    tag_t       mdl_tag   [`CACHE_SET_CNT][`CACHE_WAY_CNT];
    logic       mdl_valid [`CACHE_SET_CNT][`CACHE_WAY_CNT];
    logic       mdl_dirty [`CACHE_SET_CNT][`CACHE_WAY_CNT];
    way_idx_t   mdl_ptr   [`CACHE_SET_CNT];
    line_addr_t exp_wb_q [$];
    line_addr_t last_wb_line = '0;

    word_t exp_word    = '0;
    word_t exp_addr    = '0;
    logic  expect_read = 1'b0;
    int    checks      = 0;
    int    errors      = 0;
    int    n_tests     = 0;
    int    test_start  = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    data_cache DUT (
        .clk                  (clk),
        .rst                  (rst),
        .cpu_req_i            (cpu_req),
        .request_finish_o     (request_finish),
        .read_data_o          (read_data),
        .miss_o               (miss),
        .mem_req_o            (mem_req),
        .mem_request_finish_i (mem_finish),
        .mem_read_line_i      (mem_line)
    );

    tb_main_memory u_memory (
        .clk         (clk),
        .rst         (rst),
        .mem_req_i   (mem_req),
        .finish_o    (mem_finish),
        .read_line_o (mem_line),
        .wb_valid_o  (wb_valid),
        .wb_line_o   (wb_line)
    );

    task automatic check_word(input word_t got, input word_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_line_addr(input line_addr_t got, input line_addr_t exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got line %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %b expected %b", $time, msg, got, exp);
        end
    endtask

    // same contents as the memory model starts with
    function automatic word_t init_word(line_addr_t line, word_sel_t ws);
        return ({16'h0, line, ws} * 32'h9e37_79b1) ^ 32'ha5c3_0f1e;
    endfunction

    // byte offset 0 is the top byte
    function automatic word_t merge_store(word_t old, store_type_e st, byte_off_t off, word_t wd);
        word_t res;
        res = old;
        if (st == STORE_BYTE)
            res[8 * (3 - int'(off)) +: 8] = wd[7:0];
        else if (st == STORE_HALF)
        begin
            // odd offsets drop the store
            if (off == 2'd0)
                res[31:16] = wd[15:0];
            else if (off == 2'd2)
                res[15:0] = wd[15:0];
        end
        else
            res = wd;
        return res;
    endfunction

    // read value or the word after the store
    function automatic word_t shadow_access(cpu_req_t req);
        addr_fields_t f;
        word_addr_t   key;
        word_t        cur;
        f   = addr_fields_t'(req.addr[$bits(addr_fields_t)-1:0]);
        key = {f.tag, f.set, f.word_sel};
        if (shadow.exists(key))
            cur = shadow[key];
        else
            cur = init_word({f.tag, f.set}, f.word_sel);
        if (req.read)
            return cur;
        shadow[key] = merge_store(cur, req.store_type, f.byte_off, req.wdata);
        return shadow[key];
    endfunction

    // fifo replacement per set
    // a line turns dirty only after a store
    task automatic predict_tags(input addr_fields_t f, input logic is_store, output logic exp_miss,
                                output logic exp_wb, output line_addr_t exp_line);
        int       hit_w;
        way_idx_t v;
        hit_w = -1;
        for (int w = 0; w < `CACHE_WAY_CNT; w++)
            if (mdl_valid[f.set][w] && mdl_tag[f.set][w] == f.tag)
                hit_w = w;
        exp_miss = (hit_w < 0);
        exp_wb   = 1'b0;
        exp_line = {f.tag, f.set};
        if (exp_miss)
        begin
            v = mdl_ptr[f.set];
            if (mdl_valid[f.set][v] && mdl_dirty[f.set][v])
            begin
                exp_wb   = 1'b1;
                exp_line = {mdl_tag[f.set][v], f.set};
                exp_wb_q.push_back(exp_line);
            end
            mdl_valid[f.set][v] = 1'b1;
            mdl_dirty[f.set][v] = 1'b0;
            mdl_tag[f.set][v]   = f.tag;
            mdl_ptr[f.set]      = way_idx_t'((int'(v) + 1) % `CACHE_WAY_CNT);
            hit_w = int'(v);
        end
        if (is_store)
            mdl_dirty[f.set][hit_w] = 1'b1;
    endtask

    function automatic word_t make_addr(tag_t tag, set_idx_t si, word_sel_t ws, byte_off_t off);
        return word_t'({tag, si, ws, off});
    endfunction

    function automatic word_t random_addr(int tag_base, int tag_span, int set_base, int set_span);
        return make_addr(tag_t'(tag_base + $urandom_range(tag_span - 1)),
                         set_idx_t'(set_base + $urandom_range(set_span - 1)),
                         word_sel_t'($urandom_range(7)), byte_off_t'($urandom_range(3)));
    endfunction

    // unknown codes 3 to 7 included
    function automatic store_type_e random_store_type();
        logic [2:0] code;
        code = 3'($urandom_range(7));
        return store_type_e'(code);
    endfunction

    // one cpu request held until request_finish_o
    task automatic run_request(input logic is_read, input store_type_e st, input word_t addr,
                               input word_t wdata);
        addr_fields_t f;
        logic         exp_miss;
        logic         exp_wb;
        logic         saw_mem;
        logic         first_write;
        line_addr_t   exp_line;
        line_addr_t   first_line;
        int           cycles;
        f = addr_fields_t'(addr[$bits(addr_fields_t)-1:0]);
        predict_tags(f, !is_read, exp_miss, exp_wb, exp_line);
        @(negedge clk);
        cpu_req.read       = is_read;
        cpu_req.write      = !is_read;
        cpu_req.store_type = st;
        cpu_req.addr       = addr;
        cpu_req.wdata      = wdata;
        exp_addr    = addr;
        exp_word    = shadow_access(cpu_req);
        expect_read = is_read;
        // miss_o is combinational on the request
        #1;
        check_flag(miss, exp_miss, "miss_o at request");
        cycles      = 0;
        saw_mem     = 1'b0;
        first_write = 1'b0;
        first_line  = '0;
        do
        begin
            @(negedge clk);
            cycles++;
            if (mem_req.read && mem_req.write)
            begin
                errors++;
                $display("memory read and write were raised together at %0t", $time);
            end
            if (!saw_mem && (mem_req.read || mem_req.write))
            begin
                saw_mem     = 1'b1;
                first_write = mem_req.write;
                first_line  = mem_req.addr[`CACHE_OFFSET_LEN +: $bits(line_addr_t)];
            end
        end
        while (!request_finish && cycles < REQ_TIMEOUT);
        cpu_req.read  = 1'b0;
        cpu_req.write = 1'b0;
        if (!request_finish)
        begin
            errors++;
            $display("request to %h got no request_finish_o in %0d cycles", addr, REQ_TIMEOUT);
        end
        check_flag(saw_mem, exp_miss, "memory request only on a miss");
        if (exp_miss)
        begin
            check_flag(first_write, exp_wb, "write-back before refill");
            check_line_addr(first_line, exp_line, "first memory request");
        end
        else
            check_flag(cycles == 1, 1'b1, "hit finishes one cycle after sampling");
    endtask

    task automatic close_test(input string name);
        // the read compare of the same falling edge goes first
        #1;
        n_tests++;
        $display("test %0d %s: %0d errors", n_tests, name, errors - test_start);
        test_start = errors;
    endtask

    // read data compared in the cycle of request_finish_o
    always @(negedge clk)
    begin
        if (!rst && request_finish && expect_read)
            check_word(read_data, exp_word, $sformatf("read data at %h", exp_addr));
    end

    // write-backs must come in the predicted order
    always @(posedge clk)
    begin
        if (wb_valid)
        begin
            last_wb_line <= wb_line;
            if (exp_wb_q.size() == 0)
            begin
                errors++;
                $display("unexpected write-back of line %h at %0t", wb_line, $time);
            end
            else
                check_line_addr(wb_line, exp_wb_q.pop_front(), "write-back line");
        end
    end

    // run budget from the request count
    initial
    begin
        #((RESET_CYCLES + TOTAL_REQS * REQ_TIMEOUT) * CLK_PERIOD);
        $display("timeout: the tests did not complete in the expected time");
        $display("Verification failed");
        $finish;
    end

    initial
    begin
        word_t a;
        void'($urandom(32'h48b2));
        cpu_req = '0;
        for (int s = 0; s < `CACHE_SET_CNT; s++)
        begin
            mdl_ptr[s] = '0;
            for (int w = 0; w < `CACHE_WAY_CNT; w++)
            begin
                mdl_valid[s][w] = 1'b0;
                mdl_dirty[s][w] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;

        check_flag(request_finish, 1'b0, "request_finish_o after reset");
        check_flag(mem_req.read, 1'b0, "memory read after reset");
        check_flag(mem_req.write, 1'b0, "memory write after reset");
        check_flag(miss, 1'b0, "miss_o after reset");
        run_request(1'b1, STORE_WORD, make_addr(10'h003, 3'd1, 3'd2, 2'd0), '0);
        close_test("reset and first read");

        run_request(1'b1, STORE_WORD, make_addr(10'h003, 3'd1, 3'd5, 2'd0), '0);
        run_request(1'b1, STORE_WORD, make_addr(10'h003, 3'd1, 3'd2, 2'd0), '0);
        close_test("repeated read hit");

        for (int i = 0; i < RAND_OPS / 2; i++)
        begin
            a = random_addr(0, 2, 0, 8);
            run_request(1'b0, random_store_type(), a, $urandom);
            run_request(1'b1, STORE_WORD, a, '0);
        end
        close_test("random stores and reads");

        // the fifth tag in set 5 evicts the first
        for (int k = 0; k < 5; k++)
            run_request(1'b0, STORE_WORD, make_addr(tag_t'(10'h200 + k), 3'd5, 3'd3, 2'd0), $urandom);
        check_line_addr(last_wb_line, {10'h200, 3'd5}, "evicted line");
        run_request(1'b1, STORE_WORD, make_addr(10'h200, 3'd5, 3'd3, 2'd0), '0);
        close_test("eviction and write-back");

        for (int i = 0; i < TRAFFIC_OPS; i++)
        begin
            a = random_addr(16'h40, 8, 2, 2);
            if ($urandom_range(1) == 0)
                run_request(1'b1, STORE_WORD, a, '0);
            else
                run_request(1'b0, random_store_type(), a, $urandom);
        end
        repeat (4) @(negedge clk);
        if (exp_wb_q.size() != 0)
        begin
            errors++;
            $display("%0d predicted write-backs never reached memory", exp_wb_q.size());
        end
        close_test("sustained traffic");

        $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_main_memory.sv
`default_nettype none
`timescale 1ns/100ps

`include "cache_params.svh"

module tb_main_memory
    import cache_addr_pkg::*, cache_xact_pkg::*;
(
    input  wire           clk,
    input  wire           rst,
    input  wire mem_req_t mem_req_i,
    output logic          finish_o,
    output cache_line_t   read_line_o,
    output logic          wb_valid_o,
    output line_addr_t    wb_line_o
);

    // only lines written back are stored, the rest come from the hash
    cache_line_t lines [line_addr_t];

    logic        fin_q   = 1'b0;
    logic        wb_q    = 1'b0;
    cache_line_t rline_q = '0;
    line_addr_t  wline_q = '0;
    logic        busy    = 1'b0;
    int unsigned wait_cnt;
    line_addr_t  req_line;

    assign finish_o    = fin_q;
    assign read_line_o = rline_q;
    assign wb_valid_o  = wb_q;
    assign wb_line_o   = wline_q;

    // initial contents, unique per line and word
    function automatic word_t init_word(line_addr_t line, word_sel_t ws);
        return ({16'h0, line, ws} * 32'h9e37_79b1) ^ 32'ha5c3_0f1e;
    endfunction

    function automatic cache_line_t fetch_line(line_addr_t line);
        cache_line_t l;
        if (lines.exists(line))
            return lines[line];
        for (int w = 0; w < `CACHE_LINE_WORDS; w++)
            l[w] = init_word(line, word_sel_t'(w));
        return l;
    endfunction

    // outputs change on the falling edge, requests are stable there
    always @(negedge clk)
    begin
        if (rst)
        begin
            fin_q <= 1'b0;
            wb_q  <= 1'b0;
            busy  <= 1'b0;
        end
        else
        begin
            fin_q <= 1'b0;
            wb_q  <= 1'b0;
            if (busy)
            begin
                // latency used up, answer with a one-cycle pulse
                if (wait_cnt == 1)
                begin
                    busy  <= 1'b0;
                    fin_q <= 1'b1;
                    if (mem_req_i.write)
                    begin
                        lines[req_line] = mem_req_i.wline;
                        wb_q    <= 1'b1;
                        wline_q <= req_line;
                    end
                    else
                    begin
                        rline_q <= fetch_line(req_line);
                    end
                end
                wait_cnt <= wait_cnt - 1;
            end
            else if (!fin_q && (mem_req_i.read || mem_req_i.write))
            begin
                // 2 to 6 cycles
                busy     <= 1'b1;
                wait_cnt <= 2 + $urandom_range(4);
                req_line <= mem_req_i.addr[`CACHE_OFFSET_LEN +: $bits(line_addr_t)];
            end
        end
    end

endmodule

`default_nettype wire
